/* soc_config.svh */
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// register bus geometry
////////////////////////////////////////////////////////////////////////////

// byte address and data width of the register bus
`define SOC_ADDR_W 16
`define SOC_DATA_W 32

// slot field is addr[15:12], register index is addr[5:2]
`define SOC_SLOT_LSB 12
`define SOC_REG_LSB 2

////////////////////////////////////////////////////////////////////////////
// peripheral sizing
////////////////////////////////////////////////////////////////////////////

`define SOC_GPIO_W 12
// source 0 is gpio, source 1 is the external pin
`define SOC_IRQ_W 2
// mtime advances once per this many clocks
`define SOC_TIMER_DIV 4

`endif

/* soc_pkg.sv */
package soc_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // slot map, decoded from the slot field of the address
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    SLOT_CLINT = 4'd0,
    SLOT_PLIC  = 4'd1,
    SLOT_GPIO  = 4'd2
  } t_slot;

  // clint registers, time pair is read-only, msip uses bit 0 only
  typedef enum logic [3:0] {
    CLINT_MSIP    = 4'd0,
    CLINT_CMP_LO  = 4'd1,
    CLINT_CMP_HI  = 4'd2,
    CLINT_TIME_LO = 4'd3,
    CLINT_TIME_HI = 4'd4
  } t_clint_reg;

  // interrupt controller registers, pending and claim are read-only
  typedef enum logic [3:0] {
    IRQ_PENDING = 4'd0,
    IRQ_ENABLE  = 4'd1,
    IRQ_CLAIM   = 4'd2
  } t_irq_reg;

  // gpio registers, pend is write-one-to-clear
  typedef enum logic [3:0] {
    GPIO_IN   = 4'd0,
    GPIO_OUT  = 4'd1,
    GPIO_DIR  = 4'd2,
    GPIO_IE   = 4'd3,
    GPIO_PEND = 4'd4
  } t_gpio_reg;

  // bus controller FSM
  typedef enum logic [1:0] {ST_IDLE, ST_ACCESS, ST_RESP} t_bus_state;

endpackage

/* bus_ctrl.sv */
`timescale 1ns/100ps
`include "soc_config.svh"

module bus_ctrl (
  input                         i_clk,
  input                         i_reset,
  // request channel from the master
  input                         i_req_valid,
  output logic                  o_req_ready,
  input [`SOC_ADDR_W-1:0]       i_req_addr,
  input                         i_req_we,
  input [`SOC_DATA_W-1:0]       i_req_wdata,
  // response channel back to the master
  output logic                  o_resp_valid,
  input                         i_resp_ready,
  output logic [`SOC_DATA_W-1:0] o_resp_rdata,
  output logic                  o_resp_err,
  // slave strobes
  output logic                  o_clint_sel,
  output logic                  o_plic_sel,
  output logic                  o_gpio_sel,
  output logic                  o_slv_we,
  output logic [3:0]            o_slv_reg,
  output logic [`SOC_DATA_W-1:0] o_slv_wdata,
  input [`SOC_DATA_W-1:0]       i_clint_rdata,
  input [`SOC_DATA_W-1:0]       i_plic_rdata,
  input [`SOC_DATA_W-1:0]       i_gpio_rdata
);

  soc_pkg::t_bus_state r_state;
  logic [3:0] r_slot;
  logic [3:0] r_reg;
  logic r_we;
  logic [`SOC_DATA_W-1:0] r_wdata;
  logic w_req_fire;
  logic w_hit_clint;
  logic w_hit_plic;
  logic w_hit_gpio;
  logic w_dec_err;
  logic [`SOC_DATA_W-1:0] w_sel_rdata;

  ////////////////////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////////////////////

  // one request in flight, ready only while idle
  assign o_req_ready = (r_state == soc_pkg::ST_IDLE);
  assign w_req_fire = i_req_valid && o_req_ready;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_state <= soc_pkg::ST_IDLE;
    end else begin
      case (r_state)
        soc_pkg::ST_IDLE:   if (i_req_valid) r_state <= soc_pkg::ST_ACCESS;
        // strobe cycle, slave registers its data on this edge
        soc_pkg::ST_ACCESS: r_state <= soc_pkg::ST_RESP;
        // hold until the master takes the response
        soc_pkg::ST_RESP:   if (i_resp_ready) r_state <= soc_pkg::ST_IDLE;
        default:            r_state <= soc_pkg::ST_IDLE;
      endcase
    end
  end

  // request latch, captured on the handshake edge
  always_ff @(posedge i_clk) begin
    if (w_req_fire) begin
      r_slot  <= i_req_addr[`SOC_SLOT_LSB+3:`SOC_SLOT_LSB];
      r_reg   <= i_req_addr[`SOC_REG_LSB+3:`SOC_REG_LSB];
      r_we    <= i_req_we;
      r_wdata <= i_req_wdata;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // slot decode and strobes
  ////////////////////////////////////////////////////////////////////////////

  assign w_hit_clint = (r_slot == soc_pkg::SLOT_CLINT);
  assign w_hit_plic  = (r_slot == soc_pkg::SLOT_PLIC);
  assign w_hit_gpio  = (r_slot == soc_pkg::SLOT_GPIO);
  // slots 3..15 are unmapped
  assign w_dec_err = !(w_hit_clint || w_hit_plic || w_hit_gpio);

  assign o_clint_sel = (r_state == soc_pkg::ST_ACCESS) && w_hit_clint;
  assign o_plic_sel  = (r_state == soc_pkg::ST_ACCESS) && w_hit_plic;
  assign o_gpio_sel  = (r_state == soc_pkg::ST_ACCESS) && w_hit_gpio;
  assign o_slv_we    = r_we;
  assign o_slv_reg   = r_reg;
  assign o_slv_wdata = r_wdata;

  ////////////////////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////////////////////

  // slave data is registered and only moves on its strobe, so it holds in ST_RESP
  always_comb begin
    w_sel_rdata = '0;
    if (w_hit_clint) begin
      w_sel_rdata = i_clint_rdata;
    end else if (w_hit_plic) begin
      w_sel_rdata = i_plic_rdata;
    end else if (w_hit_gpio) begin
      w_sel_rdata = i_gpio_rdata;
    end
  end

  assign o_resp_valid = (r_state == soc_pkg::ST_RESP);
  assign o_resp_err   = o_resp_valid && w_dec_err;
  // writes and errors return zero data
  assign o_resp_rdata = (o_resp_valid && !r_we && !w_dec_err) ? w_sel_rdata : '0;

  // response must not move under back-pressure
  a_resp_hold: assert property (@(posedge i_clk) disable iff (i_reset)
    o_resp_valid && !i_resp_ready |=>
      o_resp_valid && $stable(o_resp_rdata) && $stable(o_resp_err));

endmodule

/* clint_timer.sv */
`timescale 1ns/100ps
`include "soc_config.svh"

module clint_timer (
  input                          i_clk,
  input                          i_reset,
  input                          i_sel,
  input                          i_we,
  input [3:0]                    i_reg,
  input [`SOC_DATA_W-1:0]        i_wdata,
  output logic [`SOC_DATA_W-1:0] o_rdata,
  output logic                   o_mtip,
  output logic                   o_msip
);

  localparam int DIV_W = $clog2(`SOC_TIMER_DIV);
  localparam int PAD_W = `SOC_DATA_W - 1;

  logic [DIV_W-1:0] r_div;
  logic w_tick;
  logic [63:0] r_mtime;
  logic [63:0] r_mtimecmp;
  logic r_msip;
  logic r_mtip;
  logic [`SOC_DATA_W-1:0] r_rdata;

  ////////////////////////////////////////////////////////////////////////////
  // mtime
  ////////////////////////////////////////////////////////////////////////////

  // prescaler wraps every SOC_TIMER_DIV clocks
  assign w_tick = (r_div == DIV_W'(`SOC_TIMER_DIV - 1));

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_div   <= '0;
      r_mtime <= '0;
    end else begin
      r_div <= w_tick ? '0 : r_div + 1'b1;
      if (w_tick) begin
        r_mtime <= r_mtime + 64'd1;
      end
    end
  end

  // registered compare, lags mtime by one clock
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_mtip <= 1'b0;
    end else begin
      r_mtip <= (r_mtime >= r_mtimecmp);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // register access
  ////////////////////////////////////////////////////////////////////////////

  // compare resets to all ones so mtip stays low
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_mtimecmp <= '1;
      r_msip     <= 1'b0;
    end else if (i_sel && i_we) begin
      case (i_reg)
        soc_pkg::CLINT_MSIP:   r_msip <= i_wdata[0];
        soc_pkg::CLINT_CMP_LO: r_mtimecmp[`SOC_DATA_W-1:0] <= i_wdata;
        soc_pkg::CLINT_CMP_HI: r_mtimecmp[63:`SOC_DATA_W] <= i_wdata;
        // time pair is read-only
        default: ;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_sel && !i_we) begin
      case (i_reg)
        soc_pkg::CLINT_MSIP:    r_rdata <= {{PAD_W{1'b0}}, r_msip};
        soc_pkg::CLINT_CMP_LO:  r_rdata <= r_mtimecmp[`SOC_DATA_W-1:0];
        soc_pkg::CLINT_CMP_HI:  r_rdata <= r_mtimecmp[63:`SOC_DATA_W];
        soc_pkg::CLINT_TIME_LO: r_rdata <= r_mtime[`SOC_DATA_W-1:0];
        soc_pkg::CLINT_TIME_HI: r_rdata <= r_mtime[63:`SOC_DATA_W];
        default:                r_rdata <= '0;
      endcase
    end
  end

  assign o_rdata = r_rdata;
  assign o_mtip  = r_mtip;
  assign o_msip  = r_msip;

  // mtime only moves forward between resets
  a_mtime_mono: assert property (@(posedge i_clk) disable iff (i_reset)
    !i_reset |=> (r_mtime >= $past(r_mtime)));

endmodule

/* irq_ctrl.sv */
`timescale 1ns/100ps
`include "soc_config.svh"

module irq_ctrl (
  input                          i_clk,
  input                          i_reset,
  input                          i_sel,
  input                          i_we,
  input [3:0]                    i_reg,
  input [`SOC_DATA_W-1:0]        i_wdata,
  output logic [`SOC_DATA_W-1:0] o_rdata,
  input [`SOC_IRQ_W-1:0]         i_irq_src,
  output logic                   o_meip
);

  // claim id is source number plus one, zero means none
  localparam int ID_W = $clog2(`SOC_IRQ_W + 1);

  logic [`SOC_IRQ_W-1:0] r_src_d;
  logic [`SOC_IRQ_W-1:0] r_pending;
  logic [`SOC_IRQ_W-1:0] r_enable;
  logic [`SOC_IRQ_W-1:0] w_rise;
  logic [`SOC_IRQ_W-1:0] w_active;
  logic [`SOC_IRQ_W-1:0] w_claim_mask;
  logic [`SOC_IRQ_W-1:0] w_clear;
  logic [ID_W-1:0] w_claim_id;
  logic [`SOC_DATA_W-1:0] r_rdata;

  assign w_rise   = i_irq_src & ~r_src_d;
  assign w_active = r_pending & r_enable;
  // lowest set bit wins the claim
  assign w_claim_mask = w_active & (~w_active + 1'b1);

  always_comb begin
    w_claim_id = '0;
    for (int i = `SOC_IRQ_W - 1; i >= 0; i--) begin
      if (w_active[i]) w_claim_id = ID_W'(i + 1);
    end
  end

  // a claim read retires the source it reports
  assign w_clear = (i_sel && !i_we && i_reg == soc_pkg::IRQ_CLAIM) ? w_claim_mask : '0;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_src_d   <= '0;
      r_pending <= '0;
      r_enable  <= '0;
    end else begin
      r_src_d <= i_irq_src;
      // new edge beats a same-cycle clear
      r_pending <= (r_pending & ~w_clear) | w_rise;
      if (i_sel && i_we && i_reg == soc_pkg::IRQ_ENABLE) begin
        r_enable <= i_wdata[`SOC_IRQ_W-1:0];
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_sel && !i_we) begin
      case (i_reg)
        soc_pkg::IRQ_PENDING: r_rdata <= {{(`SOC_DATA_W-`SOC_IRQ_W){1'b0}}, r_pending};
        soc_pkg::IRQ_ENABLE:  r_rdata <= {{(`SOC_DATA_W-`SOC_IRQ_W){1'b0}}, r_enable};
        soc_pkg::IRQ_CLAIM:   r_rdata <= {{(`SOC_DATA_W-ID_W){1'b0}}, w_claim_id};
        default:              r_rdata <= '0;
      endcase
    end
  end

  assign o_rdata = r_rdata;
  assign o_meip  = |w_active;

endmodule

/* gpio_regs.sv */
`timescale 1ns/100ps
`include "soc_config.svh"

module gpio_regs (
  input                          i_clk,
  input                          i_reset,
  input                          i_sel,
  input                          i_we,
  input [3:0]                    i_reg,
  input [`SOC_DATA_W-1:0]        i_wdata,
  output logic [`SOC_DATA_W-1:0] o_rdata,
  input [`SOC_GPIO_W-1:0]        i_gpio,
  output logic [`SOC_GPIO_W-1:0] o_gpio,
  output logic [`SOC_GPIO_W-1:0] o_gpio_dir,
  output logic                   o_irq
);

  localparam int PAD_W = `SOC_DATA_W - `SOC_GPIO_W;

  logic [`SOC_GPIO_W-1:0] r_sync1;
  logic [`SOC_GPIO_W-1:0] r_sync2;
  logic [`SOC_GPIO_W-1:0] r_in_d;
  logic [`SOC_GPIO_W-1:0] w_rise;
  logic [`SOC_GPIO_W-1:0] w_clear;
  logic [`SOC_GPIO_W-1:0] r_out;
  logic [`SOC_GPIO_W-1:0] r_dir;
  logic [`SOC_GPIO_W-1:0] r_ie;
  logic [`SOC_GPIO_W-1:0] r_pend;
  logic [`SOC_DATA_W-1:0] r_rdata;

  ////////////////////////////////////////////////////////////////////////////
  // input path
  ////////////////////////////////////////////////////////////////////////////

  // pins are asynchronous, two flops before anything looks at them
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_sync1 <= '0;
      r_sync2 <= '0;
      r_in_d  <= '0;
    end else begin
      r_sync1 <= i_gpio;
      r_sync2 <= r_sync1;
      r_in_d  <= r_sync2;
    end
  end

  assign w_rise = r_sync2 & ~r_in_d;
  // write one to clear pend
  assign w_clear = (i_sel && i_we && i_reg == soc_pkg::GPIO_PEND) ?
                   i_wdata[`SOC_GPIO_W-1:0] : '0;

  ////////////////////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_out  <= '0;
      r_dir  <= '0;
      r_ie   <= '0;
      r_pend <= '0;
    end else begin
      r_pend <= (r_pend & ~w_clear) | w_rise;
      if (i_sel && i_we) begin
        case (i_reg)
          soc_pkg::GPIO_OUT: r_out <= i_wdata[`SOC_GPIO_W-1:0];
          soc_pkg::GPIO_DIR: r_dir <= i_wdata[`SOC_GPIO_W-1:0];
          soc_pkg::GPIO_IE:  r_ie  <= i_wdata[`SOC_GPIO_W-1:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_sel && !i_we) begin
      case (i_reg)
        soc_pkg::GPIO_IN:   r_rdata <= {{PAD_W{1'b0}}, r_sync2};
        soc_pkg::GPIO_OUT:  r_rdata <= {{PAD_W{1'b0}}, r_out};
        soc_pkg::GPIO_DIR:  r_rdata <= {{PAD_W{1'b0}}, r_dir};
        soc_pkg::GPIO_IE:   r_rdata <= {{PAD_W{1'b0}}, r_ie};
        soc_pkg::GPIO_PEND: r_rdata <= {{PAD_W{1'b0}}, r_pend};
        default:            r_rdata <= '0;
      endcase
    end
  end

  assign o_rdata    = r_rdata;
  assign o_gpio     = r_out;
  assign o_gpio_dir = r_dir;
  // one summary line toward the interrupt controller
  assign o_irq = |(r_pend & r_ie);

endmodule

/* periph_soc.sv */
`timescale 1ns/100ps
`include "soc_config.svh"

module periph_soc (
  input                          i_clk,
  input                          i_reset,
  // request channel
  input                          i_req_valid,
  output logic                   o_req_ready,
  input [`SOC_ADDR_W-1:0]        i_req_addr,
  input                          i_req_we,
  input [`SOC_DATA_W-1:0]        i_req_wdata,
  // response channel
  output logic                   o_resp_valid,
  input                          i_resp_ready,
  output logic [`SOC_DATA_W-1:0] o_resp_rdata,
  output logic                   o_resp_err,
  // GPIO pins
  input [`SOC_GPIO_W-1:0]        i_gpio,
  output logic [`SOC_GPIO_W-1:0] o_gpio,
  output logic [`SOC_GPIO_W-1:0] o_gpio_dir,
  // interrupts
  input                          i_ext_irq,
  output logic                   o_mtip,
  output logic                   o_msip,
  output logic                   o_meip
);

  logic w_clint_sel;
  logic w_plic_sel;
  logic w_gpio_sel;
  logic w_slv_we;
  logic [3:0] wb_slv_reg;
  logic [`SOC_DATA_W-1:0] wb_slv_wdata;
  logic [`SOC_DATA_W-1:0] wb_clint_rdata;
  logic [`SOC_DATA_W-1:0] wb_plic_rdata;
  logic [`SOC_DATA_W-1:0] wb_gpio_rdata;
  logic w_gpio_irq;

  ////////////////////////////////////////////////////////////////////////////
  // bus controller, slot decode
  ////////////////////////////////////////////////////////////////////////////
  bus_ctrl ctrl0 (
    .i_clk(i_clk),
    .i_reset(i_reset),
    .i_req_valid(i_req_valid),
    .o_req_ready(o_req_ready),
    .i_req_addr(i_req_addr),
    .i_req_we(i_req_we),
    .i_req_wdata(i_req_wdata),
    .o_resp_valid(o_resp_valid),
    .i_resp_ready(i_resp_ready),
    .o_resp_rdata(o_resp_rdata),
    .o_resp_err(o_resp_err),
    .o_clint_sel(w_clint_sel),
    .o_plic_sel(w_plic_sel),
    .o_gpio_sel(w_gpio_sel),
    .o_slv_we(w_slv_we),
    .o_slv_reg(wb_slv_reg),
    .o_slv_wdata(wb_slv_wdata),
    .i_clint_rdata(wb_clint_rdata),
    .i_plic_rdata(wb_plic_rdata),
    .i_gpio_rdata(wb_gpio_rdata)
  );

  // slot 0, machine timer
  clint_timer clint0 (
    .i_clk(i_clk),
    .i_reset(i_reset),
    .i_sel(w_clint_sel),
    .i_we(w_slv_we),
    .i_reg(wb_slv_reg),
    .i_wdata(wb_slv_wdata),
    .o_rdata(wb_clint_rdata),
    .o_mtip(o_mtip),
    .o_msip(o_msip)
  );

  // slot 1, source 0 is gpio and source 1 the external pin
  irq_ctrl plic0 (
    .i_clk(i_clk),
    .i_reset(i_reset),
    .i_sel(w_plic_sel),
    .i_we(w_slv_we),
    .i_reg(wb_slv_reg),
    .i_wdata(wb_slv_wdata),
    .o_rdata(wb_plic_rdata),
    .i_irq_src({i_ext_irq, w_gpio_irq}),
    .o_meip(o_meip)
  );

  // slot 2
  gpio_regs gpio0 (
    .i_clk(i_clk),
    .i_reset(i_reset),
    .i_sel(w_gpio_sel),
    .i_we(w_slv_we),
    .i_reg(wb_slv_reg),
    .i_wdata(wb_slv_wdata),
    .o_rdata(wb_gpio_rdata),
    .i_gpio(i_gpio),
    .o_gpio(o_gpio),
    .o_gpio_dir(o_gpio_dir),
    .o_irq(w_gpio_irq)
  );

endmodule

/* tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// reference model of the peripheral registers
////////////////////////////////////////////////////////////////////////////

// shadow copies of the writable registers
logic [`SOC_GPIO_W-1:0] m_gpio_out;
logic [`SOC_GPIO_W-1:0] m_gpio_dir;
logic [`SOC_GPIO_W-1:0] m_gpio_ie;
logic [63:0]            m_cmp;
logic                   m_msip;
logic [`SOC_IRQ_W-1:0]  m_irq_en;
// input history, gpio pending bits and the interrupt controller pending bits
logic [`SOC_GPIO_W-1:0] m_gpio_in;
logic [`SOC_GPIO_W-1:0] m_gpio_pend;
logic                   m_gpio_irq;
logic [`SOC_IRQ_W-1:0]  m_irq_pend;

task automatic check_value(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
  if (expected !== actual) begin
    $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
    $display("Errors found");
    $fatal(1, "value mismatch in %s", name);
  end
endtask

function automatic void reset_shadow();
  m_gpio_out  = '0;
  m_gpio_dir  = '0;
  m_gpio_ie   = '0;
  m_cmp       = '1;
  m_msip      = 1'b0;
  m_irq_en    = '0;
  m_gpio_in   = '0;
  m_gpio_pend = '0;
  m_gpio_irq  = 1'b0;
  m_irq_pend  = '0;
endfunction

// byte address from the slot field and the register index
function automatic logic [`SOC_ADDR_W-1:0] addr_of(input logic [3:0] slot,
                                                  input logic [3:0] rg);
  logic [`SOC_ADDR_W-1:0] a;
  a = '0;
  a[`SOC_SLOT_LSB +: 4] = slot;
  a[`SOC_REG_LSB +: 4]  = rg;
  return a;
endfunction

// gpio summary line, a rising level pends source 0
function automatic void irq_line_update();
  logic line;
  line = |(m_gpio_pend & m_gpio_ie);
  if (line && !m_gpio_irq) m_irq_pend[0] = 1'b1;
  m_gpio_irq = line;
endfunction

function automatic void track_gpio_input(input logic [`SOC_GPIO_W-1:0] value);
  m_gpio_pend = m_gpio_pend | (value & ~m_gpio_in);
  m_gpio_in   = value;
  irq_line_update();
endfunction

function automatic void apply_write(input logic [3:0] slot, input logic [3:0] rg,
                                    input logic [`SOC_DATA_W-1:0] data);
  if (slot == soc_pkg::SLOT_CLINT) begin
    if (rg == soc_pkg::CLINT_MSIP) m_msip = data[0];
    if (rg == soc_pkg::CLINT_CMP_LO) m_cmp[31:0] = data;
    if (rg == soc_pkg::CLINT_CMP_HI) m_cmp[63:32] = data;
  end else if (slot == soc_pkg::SLOT_PLIC) begin
    if (rg == soc_pkg::IRQ_ENABLE) m_irq_en = data[`SOC_IRQ_W-1:0];
  end else if (slot == soc_pkg::SLOT_GPIO) begin
    if (rg == soc_pkg::GPIO_OUT) m_gpio_out = data[`SOC_GPIO_W-1:0];
    if (rg == soc_pkg::GPIO_DIR) m_gpio_dir = data[`SOC_GPIO_W-1:0];
    if (rg == soc_pkg::GPIO_IE) m_gpio_ie = data[`SOC_GPIO_W-1:0];
    // pend is write one to clear
    if (rg == soc_pkg::GPIO_PEND) m_gpio_pend = m_gpio_pend & ~data[`SOC_GPIO_W-1:0];
    irq_line_update();
  end
endfunction

// expected read data of the registers with a known value
function automatic logic [`SOC_DATA_W-1:0] expected_read(input logic [3:0] slot,
                                                        input logic [3:0] rg);
  logic [`SOC_DATA_W-1:0] v;
  v = '0;
  if (slot == soc_pkg::SLOT_CLINT) begin
    if (rg == soc_pkg::CLINT_MSIP) v[0] = m_msip;
    if (rg == soc_pkg::CLINT_CMP_LO) v = m_cmp[31:0];
    if (rg == soc_pkg::CLINT_CMP_HI) v = m_cmp[63:32];
  end else if (slot == soc_pkg::SLOT_PLIC) begin
    if (rg == soc_pkg::IRQ_ENABLE) v[`SOC_IRQ_W-1:0] = m_irq_en;
    if (rg == soc_pkg::IRQ_PENDING) v[`SOC_IRQ_W-1:0] = m_irq_pend;
  end else if (slot == soc_pkg::SLOT_GPIO) begin
    if (rg == soc_pkg::GPIO_OUT) v[`SOC_GPIO_W-1:0] = m_gpio_out;
    if (rg == soc_pkg::GPIO_DIR) v[`SOC_GPIO_W-1:0] = m_gpio_dir;
    if (rg == soc_pkg::GPIO_IE) v[`SOC_GPIO_W-1:0] = m_gpio_ie;
    if (rg == soc_pkg::GPIO_PEND) v[`SOC_GPIO_W-1:0] = m_gpio_pend;
  end
  return v;
endfunction

// lowest enabled pending source wins, id is its number plus one
function automatic logic [`SOC_DATA_W-1:0] predict_claim();
  logic [`SOC_IRQ_W-1:0] active;
  logic [`SOC_DATA_W-1:0] id;
  active = m_irq_pend & m_irq_en;
  id = '0;
  for (int i = 0; i < `SOC_IRQ_W; i++) begin
    if (active[i] && id == 0) begin
      id = i + 1;
      m_irq_pend[i] = 1'b0;
    end
  end
  return id;
endfunction

function automatic logic meip_level();
  return |(m_irq_pend & m_irq_en);
endfunction

`endif

/* tb_periph_soc.sv */
`timescale 1ns/100ps
`include "soc_config.svh"

module tb_periph_soc;

  localparam int CLK_HALF = 4;
  // watchdog budget in transactions and cycles per transaction
  localparam int N_TRANS = 400;
  localparam int CYC_PER_TRANS = 20;
  localparam int MTIP_LIMIT = 8 * `SOC_TIMER_DIV + 4;

  logic                   i_clk;
  logic                   i_reset;
  logic                   i_req_valid;
  logic                   o_req_ready;
  logic [`SOC_ADDR_W-1:0] i_req_addr;
  logic                   i_req_we;
  logic [`SOC_DATA_W-1:0] i_req_wdata;
  logic                   o_resp_valid;
  logic                   i_resp_ready;
  logic [`SOC_DATA_W-1:0] o_resp_rdata;
  logic                   o_resp_err;
  logic [`SOC_GPIO_W-1:0] i_gpio;
  logic [`SOC_GPIO_W-1:0] o_gpio;
  logic [`SOC_GPIO_W-1:0] o_gpio_dir;
  logic                   i_ext_irq;
  logic                   o_mtip;
  logic                   o_msip;
  logic                   o_meip;
  integer                 seed = 41883;

  `include "tb_model.svh"

  periph_soc uut (.*);

  always #CLK_HALF i_clk = ~i_clk;

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // bus master, drives on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic bus_access(input logic we, input logic [`SOC_ADDR_W-1:0] addr,
                            input logic [`SOC_DATA_W-1:0] wdata,
                            output logic [`SOC_DATA_W-1:0] rdata, output logic err);
    logic [31:0] r;
    logic got;
    logic seen;
    got = 1'b0;
    seen = 1'b0;
    rdata = '0;
    err = 1'b0;
    @(negedge i_clk);
    i_req_valid = 1'b1;
    i_req_addr  = addr;
    i_req_we    = we;
    i_req_wdata = wdata;
    while (!o_req_ready) @(negedge i_clk);
    // accepted on the edge just passed, strobe cycle now
    @(negedge i_clk);
    i_req_valid = 1'b0;
    check_value("resp_valid in access cycle", 0, o_resp_valid);
    // response due on the next cycle, then held until ready
    while (!got) begin
      @(negedge i_clk);
      r = rand_word();
      i_resp_ready = (r[1:0] != 2'b00);
      check_value("resp_valid", 1, o_resp_valid);
      check_value("req_ready while response pending", 0, o_req_ready);
      if (seen) begin
        check_value("rdata held", rdata, o_resp_rdata);
        check_value("err held", err, o_resp_err);
      end
      rdata = o_resp_rdata;
      err   = o_resp_err;
      seen  = 1'b1;
      got   = i_resp_ready;
    end
  endtask

  task automatic write_reg(input logic [3:0] slot, input logic [3:0] rg,
                           input logic [`SOC_DATA_W-1:0] data);
    logic [`SOC_DATA_W-1:0] rd;
    logic err;
    apply_write(slot, rg, data);
    bus_access(1'b1, addr_of(slot, rg), data, rd, err);
    check_value("write err", 0, err);
    check_value("write rdata", 0, rd);
  endtask

  task automatic read_reg(input logic [3:0] slot, input logic [3:0] rg,
                          output logic [`SOC_DATA_W-1:0] data);
    logic err;
    bus_access(1'b0, addr_of(slot, rg), rand_word(), data, err);
    check_value("read err", 0, err);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequences
  ////////////////////////////////////////////////////////////////////////////

  task automatic round_trip_regs(input int n);
    logic [31:0] r;
    logic [31:0] rd;
    logic [3:0] slot;
    logic [3:0] rg;
    for (int k = 0; k < n; k++) begin
      r = rand_word();
      case (r % 7)
        0: begin
          slot = soc_pkg::SLOT_GPIO;
          rg   = soc_pkg::GPIO_OUT;
        end
        1: begin
          slot = soc_pkg::SLOT_GPIO;
          rg   = soc_pkg::GPIO_DIR;
        end
        2: begin
          slot = soc_pkg::SLOT_GPIO;
          rg   = soc_pkg::GPIO_IE;
        end
        3: begin
          slot = soc_pkg::SLOT_CLINT;
          rg   = soc_pkg::CLINT_CMP_LO;
        end
        4: begin
          slot = soc_pkg::SLOT_CLINT;
          rg   = soc_pkg::CLINT_CMP_HI;
        end
        5: begin
          slot = soc_pkg::SLOT_PLIC;
          rg   = soc_pkg::IRQ_ENABLE;
        end
        default: begin
          slot = soc_pkg::SLOT_CLINT;
          rg   = soc_pkg::CLINT_MSIP;
        end
      endcase
      if (r[8]) begin
        write_reg(slot, rg, rand_word());
        // pins follow the registers as soon as the write has landed
        check_value("o_gpio", m_gpio_out, o_gpio);
        check_value("o_gpio_dir", m_gpio_dir, o_gpio_dir);
        check_value("o_msip", m_msip, o_msip);
      end else begin
        read_reg(slot, rg, rd);
        check_value("register read back", expected_read(slot, rg), rd);
      end
    end
  endtask

  // slots 3..15 are unmapped
  task automatic decode_errors(input int n);
    logic [31:0] r;
    logic [31:0] rd;
    logic err;
    logic [3:0] slot;
    for (int k = 0; k < n; k++) begin
      r = rand_word();
      slot = 4'(3 + (r % 13));
      bus_access(r[8], addr_of(slot, r[15:12]), rand_word(), rd, err);
      check_value("decode err", 1, err);
      check_value("decode err rdata", 0, rd);
    end
  endtask

  task automatic timer_checks();
    logic [31:0] lo;
    logic [31:0] hi;
    logic [63:0] t;
    logic [63:0] prev;
    int n;
    prev = '0;
    for (int k = 0; k < 5; k++) begin
      read_reg(soc_pkg::SLOT_CLINT, soc_pkg::CLINT_TIME_LO, lo);
      read_reg(soc_pkg::SLOT_CLINT, soc_pkg::CLINT_TIME_HI, hi);
      t = {hi, lo};
      check_value("mtime order", 1, t >= prev);
      prev = t;
    end
    // park the compare, mtip is registered so allow one more edge
    write_reg(soc_pkg::SLOT_CLINT, soc_pkg::CLINT_CMP_HI, '1);
    write_reg(soc_pkg::SLOT_CLINT, soc_pkg::CLINT_CMP_LO, '1);
    repeat (2) @(negedge i_clk);
    check_value("mtip parked", 0, o_mtip);
    read_reg(soc_pkg::SLOT_CLINT, soc_pkg::CLINT_TIME_LO, lo);
    read_reg(soc_pkg::SLOT_CLINT, soc_pkg::CLINT_TIME_HI, hi);
    t = {hi, lo} + 64'd8;
    // high half first keeps the compare above mtime in between
    write_reg(soc_pkg::SLOT_CLINT, soc_pkg::CLINT_CMP_HI, t[63:32]);
    write_reg(soc_pkg::SLOT_CLINT, soc_pkg::CLINT_CMP_LO, t[31:0]);
    check_value("mtip before compare", 0, o_mtip);
    n = 0;
    while (!o_mtip && n < MTIP_LIMIT) begin
      @(negedge i_clk);
      n++;
    end
    check_value("mtip rise", 1, o_mtip);
    write_reg(soc_pkg::SLOT_CLINT, soc_pkg::CLINT_CMP_HI, '1);
    write_reg(soc_pkg::SLOT_CLINT, soc_pkg::CLINT_CMP_LO, '1);
    repeat (2) @(negedge i_clk);
    check_value("mtip clear", 0, o_mtip);
  endtask

  task automatic gpio_edges(input int n);
    logic [31:0] r;
    logic [31:0] rd;
    write_reg(soc_pkg::SLOT_GPIO, soc_pkg::GPIO_IE, rand_word() | 32'h1);
    // only the gpio source reaches meip here
    write_reg(soc_pkg::SLOT_PLIC, soc_pkg::IRQ_ENABLE, 32'h1);
    for (int k = 0; k < n; k++) begin
      r = rand_word();
      @(negedge i_clk);
      i_gpio = r[`SOC_GPIO_W-1:0];
      track_gpio_input(r[`SOC_GPIO_W-1:0]);
      // past the synchronizer and edge detector
      repeat (3 + r[13:12]) @(negedge i_clk);
      read_reg(soc_pkg::SLOT_GPIO, soc_pkg::GPIO_IN, rd);
      check_value("gpio in", i_gpio, rd);
      read_reg(soc_pkg::SLOT_GPIO, soc_pkg::GPIO_PEND, rd);
      check_value("gpio pend", expected_read(soc_pkg::SLOT_GPIO, soc_pkg::GPIO_PEND), rd);
      check_value("meip from gpio", meip_level(), o_meip);
      write_reg(soc_pkg::SLOT_GPIO, soc_pkg::GPIO_PEND, rand_word());
      read_reg(soc_pkg::SLOT_GPIO, soc_pkg::GPIO_PEND, rd);
      check_value("gpio pend cleared",
                  expected_read(soc_pkg::SLOT_GPIO, soc_pkg::GPIO_PEND), rd);
      read_reg(soc_pkg::SLOT_PLIC, soc_pkg::IRQ_CLAIM, rd);
      check_value("gpio claim", predict_claim(), rd);
      check_value("meip after claim", meip_level(), o_meip);
    end
  endtask

  task automatic claim_sequence();
    logic [31:0] rd;
    @(negedge i_clk);
    i_gpio = '0;
    track_gpio_input('0);
    repeat (4) @(negedge i_clk);
    write_reg(soc_pkg::SLOT_GPIO, soc_pkg::GPIO_PEND, '1);
    write_reg(soc_pkg::SLOT_GPIO, soc_pkg::GPIO_IE, 32'h1);
    write_reg(soc_pkg::SLOT_PLIC, soc_pkg::IRQ_ENABLE, 32'h3);
    // raise both sources together
    @(negedge i_clk);
    i_gpio = 'h1;
    i_ext_irq = 1'b1;
    track_gpio_input('h1);
    m_irq_pend[1] = 1'b1;
    repeat (4) @(negedge i_clk);
    read_reg(soc_pkg::SLOT_PLIC, soc_pkg::IRQ_PENDING, rd);
    check_value("irq pending", 3, rd);
    check_value("meip both", 1, o_meip);
    for (int k = 0; k < 3; k++) begin
      read_reg(soc_pkg::SLOT_PLIC, soc_pkg::IRQ_CLAIM, rd);
      check_value("claim id", predict_claim(), rd);
    end
    check_value("meip after last claim", 0, o_meip);
    i_ext_irq = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    i_clk = 1'b0;
    i_reset = 1'b1;
    i_req_valid = 1'b0;
    i_req_addr = '0;
    i_req_we = 1'b0;
    i_req_wdata = '0;
    i_resp_ready = 1'b0;
    i_gpio = '0;
    i_ext_irq = 1'b0;
    reset_shadow();
    repeat (4) @(posedge i_clk);
    @(negedge i_clk);
    i_reset = 1'b0;
    check_value("reset req_ready", 1, o_req_ready);
    check_value("reset resp_valid", 0, o_resp_valid);
    check_value("reset outputs", 0, {o_gpio, o_gpio_dir, o_mtip, o_msip, o_meip});
    round_trip_regs(120);
    decode_errors(24);
    round_trip_regs(20);
    timer_checks();
    gpio_edges(24);
    claim_sequence();
    $display("No errors");
    $finish;
  end

  initial begin
    #(N_TRANS * CYC_PER_TRANS * 2 * CLK_HALF);
    $display("watchdog: the run did not finish within its time budget");
    $display("Errors found");
    $fatal(1, "timeout");
  end

endmodule

/* compile.f */
+incdir+.
soc_pkg.sv
bus_ctrl.sv
clint_timer.sv
irq_ctrl.sv
gpio_regs.sv
periph_soc.sv
tb_periph_soc.sv

/* Makefile */
TOP = tb_periph_soc

.PHONY: all build run clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module $(TOP) -Mdir obj_dir -o V$(TOP)

# pass only when the simulation prints the pass message
run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
		echo "$$out" | grep -q "No errors"

clean:
	rm -rf obj_dir
